//--- logic/ray_pkg.sv
// Fixed-point widths, latencies, item structs and arithmetic helpers shared by the ray-triangle pipeline
package ray_pkg;

	localparam int WORD_W     = 32;
	localparam int FRAC_W     = 16;
	localparam int EDGE_W     = 2 * WORD_W - FRAC_W;
	localparam int DIV_STAGES = 4;
	localparam int QUO_W      = WORD_W + FRAC_W;
	localparam int STEP_W     = QUO_W / DIV_STAGES;
	localparam int PIPE_LAT   = 18;

	typedef logic signed [WORD_W-1:0] fix_t;
	typedef logic signed [EDGE_W-1:0] edge_t;

	typedef struct packed {
		fix_t x;
		fix_t y;
		fix_t z;
	} vec3_t;

	typedef struct packed {
		vec3_t p1;
		vec3_t p2;
		vec3_t p3;
	} tri_t;

	typedef struct packed {
		vec3_t origin;
		vec3_t dir;
	} ray_t;

	typedef struct packed {
		logic [8:0] x;
		logic [8:0] y;
	} pixel_t;

	typedef struct packed {
		logic   valid;
		tri_t   triangle;
		ray_t   ray;
		pixel_t pixel;
	} ray_job_t;

	typedef struct packed {
		logic   valid;
		tri_t   triangle;
		ray_t   ray;
		vec3_t  normal;
		pixel_t pixel;
	} setup_t;

	typedef struct packed {
		logic   valid;
		logic   parallel;
		fix_t   t;
		vec3_t  point;
		vec3_t  normal;
		tri_t   triangle;
		pixel_t pixel;
	} plane_t;

	typedef struct packed {
		logic   valid;
		logic   hit;
		fix_t   t;
		vec3_t  point;
		vec3_t  normal;
		pixel_t pixel;
	} hit_result_t;

	// Full product, then keep WORD_W bits above the fraction
	function automatic fix_t fix_mul(input fix_t a, input fix_t b);
		logic signed [2*WORD_W-1:0] full;
		full = a * b;
		return full[FRAC_W +: WORD_W];
	endfunction

	// Wider variant for the edge functions
	function automatic edge_t edge_mul(input fix_t a, input fix_t b);
		logic signed [2*WORD_W-1:0] full;
		full = a * b;
		return full[FRAC_W +: EDGE_W];
	endfunction

	function automatic vec3_t vec_sub(input vec3_t a, input vec3_t b);
		vec3_t r;
		r.x = a.x - b.x;
		r.y = a.y - b.y;
		r.z = a.z - b.z;
		return r;
	endfunction

	function automatic vec3_t vec_add(input vec3_t a, input vec3_t b);
		vec3_t r;
		r.x = a.x + b.x;
		r.y = a.y + b.y;
		r.z = a.z + b.z;
		return r;
	endfunction

	// Componentwise product
	function automatic vec3_t vec_mul(input vec3_t a, input vec3_t b);
		vec3_t r;
		r.x = fix_mul(a.x, b.x);
		r.y = fix_mul(a.y, b.y);
		r.z = fix_mul(a.z, b.z);
		return r;
	endfunction

	function automatic vec3_t vec_scale(input fix_t s, input vec3_t v);
		vec3_t r;
		r.x = fix_mul(s, v.x);
		r.y = fix_mul(s, v.y);
		r.z = fix_mul(s, v.z);
		return r;
	endfunction

endpackage

//--- logic/fixed_divider.sv
// Pipelined signed fixed-point divider on magnitudes, DIV_STAGES enabled cycles from operands to quotient
module fixed_divider (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          en,
	input  logic          in_valid,
	input  ray_pkg::fix_t dividend,
	input  ray_pkg::fix_t divisor,
	output logic          out_valid,
	output ray_pkg::fix_t quotient,
	output logic          div_by_zero
);
	import ray_pkg::*;

	// acc shifts dividend bits out at the top and quotient bits in at the bottom
	typedef struct packed {
		logic              neg;
		logic              zero;
		logic [WORD_W:0]   rem;
		logic [QUO_W-1:0]  acc;
		logic [WORD_W-1:0] den;
	} div_stage_t;

	div_stage_t            first;
	div_stage_t            stg [DIV_STAGES];
	logic [DIV_STAGES-1:0] vld;
	logic [WORD_W-1:0]     mag_q;

	function automatic logic [WORD_W-1:0] magnitude(input fix_t v);
		return v[WORD_W-1] ? WORD_W'(-v) : WORD_W'(v);
	endfunction

	// Restoring division over STEP_W quotient bits
	function automatic div_stage_t div_step(input div_stage_t cur);
		div_stage_t nxt;
		nxt = cur;
		for (int b = 0; b < STEP_W; b++)
		begin
			nxt.rem = {nxt.rem[WORD_W-1:0], nxt.acc[QUO_W-1]};
			nxt.acc = {nxt.acc[QUO_W-2:0], 1'b0};
			if (nxt.rem >= {1'b0, nxt.den})
			begin
				nxt.rem    = nxt.rem - {1'b0, nxt.den};
				nxt.acc[0] = 1'b1;
			end
		end
		return nxt;
	endfunction

	always_comb
	begin
		first.neg  = dividend[WORD_W-1] ^ divisor[WORD_W-1];
		first.zero = (divisor == '0);
		first.rem  = '0;
		first.acc  = {magnitude(dividend), {FRAC_W{1'b0}}};
		first.den  = magnitude(divisor);
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			vld <= '0;
		end
		else if (en)
		begin
			vld    <= {vld[DIV_STAGES-2:0], in_valid};
			stg[0] <= div_step(first);
			for (int s = 1; s < DIV_STAGES; s++)
			begin
				stg[s] <= div_step(stg[s-1]);
			end
		end
	end

	// Sign goes back on last, which truncates toward zero
	always_comb
	begin
		mag_q = stg[DIV_STAGES-1].acc[WORD_W-1:0];
		if (stg[DIV_STAGES-1].zero)
			quotient = '0;
		else if (stg[DIV_STAGES-1].neg)
			quotient = -mag_q;
		else
			quotient = mag_q;
	end

	assign out_valid   = vld[DIV_STAGES-1];
	assign div_by_zero = stg[DIV_STAGES-1].zero;

	assert property (@(posedge clk) disable iff (!rst_n)
		en && in_valid |=> en [-> DIV_STAGES-1] ##1 out_valid)
		else $error("divider output valid missing after DIV_STAGES enabled cycles");

endmodule

//--- logic/tri_setup.sv
// Triangle setup stage: edge vectors and unnormalised face normal, three enabled cycles deep
module tri_setup (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              en,
	input  ray_pkg::ray_job_t job,
	output ray_pkg::setup_t   setup
);
	import ray_pkg::*;

	// Edges from p1
	vec3_t e1;
	vec3_t e2;

	// Cross product terms
	fix_t yz;
	fix_t zy;
	fix_t zx;
	fix_t xz;
	fix_t xy;
	fix_t yx;

	ray_job_t job_d [1:2];

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			job_d[1].valid <= 1'b0;
			job_d[2].valid <= 1'b0;
			setup.valid    <= 1'b0;
		end
		else if (en)
		begin
			// Stage 1
			e1       <= vec_sub(job.triangle.p2, job.triangle.p1);
			e2       <= vec_sub(job.triangle.p3, job.triangle.p1);
			job_d[1] <= job;

			// Stage 2
			yz       <= fix_mul(e1.y, e2.z);
			zy       <= fix_mul(e1.z, e2.y);
			zx       <= fix_mul(e1.z, e2.x);
			xz       <= fix_mul(e1.x, e2.z);
			xy       <= fix_mul(e1.x, e2.y);
			yx       <= fix_mul(e1.y, e2.x);
			job_d[2] <= job_d[1];

			// Stage 3
			setup.valid    <= job_d[2].valid;
			setup.triangle <= job_d[2].triangle;
			setup.ray      <= job_d[2].ray;
			setup.pixel    <= job_d[2].pixel;
			setup.normal.x <= yz - zy;
			setup.normal.y <= zx - xz;
			setup.normal.z <= xy - yx;
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(setup.valid))
		else $error("setup valid is unknown out of reset");

endmodule

//--- logic/plane_intersect.sv
// Plane stage: ray parameter t by pipelined division and the intersection point, eleven cycles deep
module plane_intersect (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            en,
	input  ray_pkg::setup_t setup,
	output ray_pkg::plane_t plane
);
	import ray_pkg::*;

	// Side data, index k is the item that entered k enabled cycles ago
	tri_t   tri_d [1:DIV_STAGES+6];
	ray_t   ray_d [1:DIV_STAGES+5];
	vec3_t  nrm_d [1:DIV_STAGES+6];
	pixel_t pix_d [1:DIV_STAGES+6];

	logic [3:1] pre_v;
	logic [3:1] post_v;

	vec3_t o_p2;
	vec3_t on_prod;
	vec3_t dn_prod;
	fix_t  num;
	fix_t  den;

	logic div_valid;
	logic div_zero;
	fix_t quo;

	// After the divider
	fix_t       t_r [1:3];
	logic [3:1] par_r;
	vec3_t      tdir;
	vec3_t      point;

	fixed_divider u_div (
		.clk         (clk),
		.rst_n       (rst_n),
		.en          (en),
		.in_valid    (pre_v[3]),
		.dividend    (num),
		.divisor     (den),
		.out_valid   (div_valid),
		.quotient    (quo),
		.div_by_zero (div_zero)
	);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			pre_v       <= '0;
			post_v      <= '0;
			plane.valid <= 1'b0;
		end
		else if (en)
		begin
			tri_d[1] <= setup.triangle;
			ray_d[1] <= setup.ray;
			nrm_d[1] <= setup.normal;
			pix_d[1] <= setup.pixel;
			for (int k = 2; k <= DIV_STAGES + 6; k++)
			begin
				tri_d[k] <= tri_d[k-1];
				nrm_d[k] <= nrm_d[k-1];
				pix_d[k] <= pix_d[k-1];
			end
			for (int k = 2; k <= DIV_STAGES + 5; k++)
			begin
				ray_d[k] <= ray_d[k-1];
			end

			// Plane equation terms ahead of the divider
			pre_v   <= {pre_v[2:1], setup.valid};
			o_p2    <= vec_sub(setup.ray.origin, setup.triangle.p2);
			on_prod <= vec_mul(o_p2, nrm_d[1]);
			dn_prod <= vec_mul(ray_d[1].dir, nrm_d[1]);
			num     <= -(on_prod.x + on_prod.y + on_prod.z);
			den     <= dn_prod.x + dn_prod.y + dn_prod.z;

			// t register, then t times dir, then origin added
			post_v <= {post_v[2:1], div_valid};
			par_r  <= {par_r[2:1], div_zero};
			t_r[1] <= quo;
			t_r[2] <= t_r[1];
			t_r[3] <= t_r[2];
			tdir   <= vec_scale(t_r[1], ray_d[DIV_STAGES+4].dir);
			point  <= vec_add(ray_d[DIV_STAGES+5].origin, tdir);

			plane.valid    <= post_v[3];
			plane.parallel <= par_r[3];
			plane.t        <= t_r[3];
			plane.point    <= point;
			plane.normal   <= nrm_d[DIV_STAGES+6];
			plane.triangle <= tri_d[DIV_STAGES+6];
			plane.pixel    <= pix_d[DIV_STAGES+6];
		end
	end

	// Zero flag and zero quotient must stay aligned across the divider
	assert property (@(posedge clk) disable iff (!rst_n)
		plane.valid && plane.parallel |-> plane.t == '0)
		else $error("parallel item left the plane stage with nonzero t");

endmodule

//--- logic/inside_test.sv
// Inside test: three edge functions against the normal decide the hit, four enabled cycles deep
module inside_test (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 en,
	input  ray_pkg::plane_t      plane,
	output ray_pkg::hit_result_t result
);
	import ray_pkg::*;

	plane_t side [1:3];

	// Edge k runs from vertex k, rel k is the point seen from that vertex
	vec3_t edg [3];
	vec3_t rel [3];
	vec3_t crs [3];
	edge_t efn [3];

	function automatic vec3_t cross_prod(input vec3_t a, input vec3_t b);
		vec3_t r;
		r.x = fix_mul(a.y, b.z) - fix_mul(a.z, b.y);
		r.y = fix_mul(a.z, b.x) - fix_mul(a.x, b.z);
		r.z = fix_mul(a.x, b.y) - fix_mul(a.y, b.x);
		return r;
	endfunction

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			side[1].valid <= 1'b0;
			side[2].valid <= 1'b0;
			side[3].valid <= 1'b0;
			result.valid  <= 1'b0;
		end
		else if (en)
		begin
			// Stage 1
			side[1] <= plane;
			edg[0]  <= vec_sub(plane.triangle.p2, plane.triangle.p1);
			edg[1]  <= vec_sub(plane.triangle.p3, plane.triangle.p2);
			edg[2]  <= vec_sub(plane.triangle.p1, plane.triangle.p3);
			rel[0]  <= vec_sub(plane.point, plane.triangle.p1);
			rel[1]  <= vec_sub(plane.point, plane.triangle.p2);
			rel[2]  <= vec_sub(plane.point, plane.triangle.p3);

			// Stage 2
			side[2] <= side[1];
			for (int k = 0; k < 3; k++)
			begin
				crs[k] <= cross_prod(edg[k], rel[k]);
			end

			// Stage 3, dot with the normal at EDGE_W
			side[3] <= side[2];
			for (int k = 0; k < 3; k++)
			begin
				efn[k] <= edge_mul(crs[k].x, side[2].normal.x)
					+ edge_mul(crs[k].y, side[2].normal.y)
					+ edge_mul(crs[k].z, side[2].normal.z);
			end

			// Stage 4
			result.valid  <= side[3].valid;
			result.hit    <= !side[3].parallel && !efn[0][EDGE_W-1]
				&& !efn[1][EDGE_W-1] && !efn[2][EDGE_W-1];
			result.t      <= side[3].t;
			result.point  <= side[3].point;
			result.normal <= side[3].normal;
			result.pixel  <= side[3].pixel;
		end
	end

endmodule

//--- logic/ray_tri_top.sv
// Ray-triangle intersection unit top: setup, plane and inside stages in a PIPE_LAT cycle pipeline
module ray_tri_top (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 en,
	input  ray_pkg::ray_job_t    job,
	output ray_pkg::hit_result_t result
);
	import ray_pkg::*;

	setup_t setup;
	plane_t plane;

	// Edges and normal
	tri_setup u_setup (
		.clk   (clk),
		.rst_n (rst_n),
		.en    (en),
		.job   (job),
		.setup (setup)
	);

	// t and intersection point
	plane_intersect u_plane (
		.clk   (clk),
		.rst_n (rst_n),
		.en    (en),
		.setup (setup),
		.plane (plane)
	);

	// Edge functions and hit
	inside_test u_inside (
		.clk    (clk),
		.rst_n  (rst_n),
		.en     (en),
		.plane  (plane),
		.result (result)
	);

endmodule

//--- verification/ray_tri_model.svh
// Reference model of the ray-triangle pipeline, included into the testbench module body
`ifndef RAY_TRI_MODEL_SVH
`define RAY_TRI_MODEL_SVH

// Full product shifted down by the fraction, low WORD_W bits kept
function automatic fix_t scaled_product(input fix_t a, input fix_t b);
	logic signed [2*WORD_W-1:0] wa;
	logic signed [2*WORD_W-1:0] wb;
	logic signed [2*WORD_W-1:0] p;
	wa = a;
	wb = b;
	p = (wa * wb) >>> FRAC_W;
	return p[WORD_W-1:0];
endfunction

// Same shift, EDGE_W bits kept
function automatic edge_t wide_product(input fix_t a, input fix_t b);
	logic signed [2*WORD_W-1:0] wa;
	logic signed [2*WORD_W-1:0] wb;
	logic signed [2*WORD_W-1:0] p;
	wa = a;
	wb = b;
	p = (wa * wb) >>> FRAC_W;
	return p[EDGE_W-1:0];
endfunction

function automatic vec3_t minus3(input vec3_t a, input vec3_t b);
	return '{x: a.x - b.x, y: a.y - b.y, z: a.z - b.z};
endfunction

function automatic vec3_t plus3(input vec3_t a, input vec3_t b);
	return '{x: a.x + b.x, y: a.y + b.y, z: a.z + b.z};
endfunction

function automatic vec3_t cross3(input vec3_t a, input vec3_t b);
	vec3_t r;
	r.x = scaled_product(a.y, b.z) - scaled_product(a.z, b.y);
	r.y = scaled_product(a.z, b.x) - scaled_product(a.x, b.z);
	r.z = scaled_product(a.x, b.y) - scaled_product(a.y, b.x);
	return r;
endfunction

function automatic edge_t edge_value(input vec3_t edg, input vec3_t rel, input vec3_t n);
	vec3_t c;
	c = cross3(edg, rel);
	return wide_product(c.x, n.x) + wide_product(c.y, n.y) + wide_product(c.z, n.z);
endfunction

// Quotient of num with FRAC_W zero bits appended, truncated toward zero
function automatic fix_t divide_ratio(input fix_t num, input fix_t den);
	longint mn;
	longint md;
	longint q;
	logic [WORD_W-1:0] qlo;
	mn = (num < 0) ? -longint'(num) : longint'(num);
	md = (den < 0) ? -longint'(den) : longint'(den);
	q = (mn << FRAC_W) / md;
	qlo = q[WORD_W-1:0];
	return ((num < 0) != (den < 0)) ? -qlo : qlo;
endfunction

function automatic hit_result_t expect_result(input ray_job_t j);
	hit_result_t r;
	vec3_t n;
	vec3_t op;
	fix_t num;
	fix_t den;
	logic par;
	edge_t f0;
	edge_t f1;
	edge_t f2;
	n = cross3(minus3(j.triangle.p2, j.triangle.p1), minus3(j.triangle.p3, j.triangle.p1));
	op = minus3(j.ray.origin, j.triangle.p2);
	num = -(scaled_product(op.x, n.x) + scaled_product(op.y, n.y) + scaled_product(op.z, n.z));
	den = scaled_product(j.ray.dir.x, n.x) + scaled_product(j.ray.dir.y, n.y)
		+ scaled_product(j.ray.dir.z, n.z);
	par = (den == 0);
	r.valid = 1'b1;
	r.t = par ? '0 : divide_ratio(num, den);
	r.point.x = j.ray.origin.x + scaled_product(r.t, j.ray.dir.x);
	r.point.y = j.ray.origin.y + scaled_product(r.t, j.ray.dir.y);
	r.point.z = j.ray.origin.z + scaled_product(r.t, j.ray.dir.z);
	f0 = edge_value(minus3(j.triangle.p2, j.triangle.p1), minus3(r.point, j.triangle.p1), n);
	f1 = edge_value(minus3(j.triangle.p3, j.triangle.p2), minus3(r.point, j.triangle.p2), n);
	f2 = edge_value(minus3(j.triangle.p1, j.triangle.p3), minus3(r.point, j.triangle.p3), n);
	r.hit = !par && (f0 >= 0) && (f1 >= 0) && (f2 >= 0);
	r.normal = n;
	r.pixel = j.pixel;
	return r;
endfunction

`endif

//--- verification/ray_tri_tb.sv
// Testbench for the ray-triangle unit: random and directed items scored against a model
module ray_tri_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import ray_pkg::*;

	`include "ray_tri_model.svh"

	localparam int RANDOM_ITEMS = 300;
	localparam int WAIT_LIMIT   = 4000;
	localparam fix_t ONE        = 32'sh0001_0000;

	logic        clk;
	logic        rst_n;
	logic        en;
	ray_job_t    job;
	hit_result_t result;

	// Expected items, due enabled cycle, directed code (0 miss, 1 hit, 2 none, 3 parallel)
	hit_result_t expect_q [$];
	int unsigned due_q [$];
	int unsigned req_q [$];
	int unsigned en_count = 0;
	logic        edge_en;
	hit_result_t held;
	bit          stall_mode = 0;

	ray_tri_top dut (
		.clk    (clk),
		.rst_n  (rst_n),
		.en     (en),
		.job    (job),
		.result (result)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("FAIL: see errors above");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [255:0] got,
		input logic [255:0] exp);
		if (got !== exp)
		begin
			$display("MISMATCH %s got %h expected %h", name, got, exp);
			report_failure("value check failed");
		end
	endtask

	// Acceptance seen on the same edge the DUT samples
	always @(posedge clk)
	begin
		if (rst_n && en)
		begin
			if (job.valid)
			begin
				expect_q.push_back(expect_result(job));
				due_q.push_back(en_count + PIPE_LAT);
			end
			en_count <= en_count + 1;
		end
		edge_en <= rst_n && en;
	end

	always @(negedge clk)
	begin
		hit_result_t exp;
		int unsigned req;
		if (!rst_n)
			check_value("result.valid", result.valid, 1'b0);
		else if (!edge_en)
			check_value("result (held)", result, held);
		else if (result.valid)
		begin
			if (expect_q.size() == 0)
				report_failure("output valid with no item in flight");
			if (due_q[0] != en_count)
				report_failure("item left the pipeline at the wrong enabled cycle");
			exp = expect_q.pop_front();
			void'(due_q.pop_front());
			req = req_q.pop_front();
			check_value("result.t", result.t, exp.t);
			check_value("result.point", result.point, exp.point);
			check_value("result.normal", result.normal, exp.normal);
			check_value("result.pixel", result.pixel, exp.pixel);
			check_value("result.hit", result.hit, exp.hit);
			if (req != 2)
				check_value("result.hit (directed)", result.hit, req == 1);
			if (req == 3)
				check_value("result.t (parallel)", result.t, 0);
		end
		else if (due_q.size() > 0 && due_q[0] == en_count)
			report_failure("expected item did not appear at the output");
		held = result;
	end

	function automatic fix_t random_coord();
		logic [31:0] r;
		r = $urandom;
		return {{12{r[19]}}, r[19:0]};
	endfunction

	function automatic vec3_t vec_of(input fix_t x, input fix_t y, input fix_t z);
		return '{x: x, y: y, z: z};
	endfunction

	function automatic vec3_t random_vec();
		return vec_of(random_coord(), random_coord(), random_coord());
	endfunction

	task automatic drive_item(input ray_job_t j, input int unsigned req);
		int  tries;
		logic go;
		tries = 0;
		go = 1'b0;
		req_q.push_back(req);
		while (!go)
		begin
			@(posedge clk);
			go = !stall_mode || ($urandom % 3 != 0);
			job <= j;
			en <= go;
			tries++;
			if (tries > WAIT_LIMIT)
				report_failure("timeout while driving an item");
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n)
		begin
			@(posedge clk);
			job <= '0;
			en <= !stall_mode || ($urandom % 3 != 0);
		end
	endtask

	task automatic drain_pipeline();
		int waited;
		waited = 0;
		while (expect_q.size() > 0)
		begin
			idle_cycles(1);
			waited++;
			if (waited > WAIT_LIMIT)
				report_failure("timeout waiting for the pipeline to drain");
		end
	endtask

	task automatic random_items(input int n);
		ray_job_t j;
		for (int i = 0; i < n; i++)
		begin
			j.valid = 1'b1;
			j.triangle = '{p1: random_vec(), p2: random_vec(), p3: random_vec()};
			j.ray = '{origin: random_vec(), dir: random_vec()};
			j.pixel = '{x: i[8:0], y: 9'($urandom)};
			drive_item(j, 2);
		end
	endtask

	// Right triangles in a z plane, hit at the centroid, miss beyond p2, in-plane ray
	task automatic directed_items();
		ray_job_t j;
		vec3_t cen;
		fix_t ox;
		fix_t oy;
		fix_t zc;
		for (int k = 0; k < 4; k++)
		begin
			ox = k * ONE - 2 * ONE;
			oy = ONE / 2 - k * (ONE / 4);
			zc = k * (ONE / 2) - ONE;
			j.valid = 1'b1;
			j.pixel = '{x: 9'(500 + k), y: 9'(k)};
			j.triangle.p1 = vec_of(ox, oy, zc);
			j.triangle.p2 = vec_of(ox + 4 * ONE, oy, zc);
			j.triangle.p3 = vec_of(ox, oy + 4 * ONE, zc);
			cen = vec_of(ox + 32'sd87381, oy + 32'sd87381, zc);
			j.ray.origin = plus3(cen, vec_of(ONE / 2, -(ONE / 4), 3 * ONE));
			j.ray.dir = minus3(cen, j.ray.origin);
			drive_item(j, 1);
			j.ray.dir = minus3(plus3(j.triangle.p2, minus3(j.triangle.p2, cen)), j.ray.origin);
			drive_item(j, 0);
			j.ray.dir = vec_of(ONE, ONE / 2, '0);
			drive_item(j, 3);
		end
	endtask

	initial
	begin
		rst_n = 1'b0;
		en = 1'b0;
		job = '0;
		void'($urandom(32'h6b88b264));
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;

		// Output stays quiet with nothing accepted
		idle_cycles(2 * PIPE_LAT);

		random_items(RANDOM_ITEMS);
		directed_items();
		drain_pipeline();

		stall_mode = 1;
		random_items(RANDOM_ITEMS / 2);
		directed_items();
		drain_pipeline();
		stall_mode = 0;
		idle_cycles(PIPE_LAT);

		$display("PASS: all tests");
		$finish;
	end

endmodule

//--- ray_tri_top.f
+incdir+verification
logic/ray_pkg.sv
logic/fixed_divider.sv
logic/tri_setup.sv
logic/plane_intersect.sv
logic/inside_test.sv
logic/ray_tri_top.sv
verification/ray_tri_tb.sv
